// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - rtl/mem_pkg.sv
  - rtl/lane_align.sv
  - rtl/load_unit.sv
  - rtl/store_unit.sv
  - rtl/mem_arbiter.sv
  - rtl/word_ram.sv
  - rtl/mem_subsystem.sv
  - target: test
    files:
      - test/tb_mem_subsystem.sv

// ==== rtl/lane_align.sv ====
// ----------------------------------------------------------------------
// Lane mask, shift amount and alignment check for one memory access
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lane_align (
    input  wire mem_pkg::addr_t  addr,
    input  wire mem_pkg::size_t  size,
    output mem_pkg::word_t       mask,
    output mem_pkg::shift_t      shift,
    output logic                 misaligned
);

    logic [mem_pkg::OFFSET_BITS-1:0] byte_offset;

    assign byte_offset = addr[mem_pkg::OFFSET_BITS-1:0];

    // Byte offset times eight gives the bit position of the lowest lane
    assign shift = {byte_offset, 3'b000};

    always_comb
    begin
        case (size)
            mem_pkg::SIZE_BYTE:
            begin
                mask       = mem_pkg::BYTE_MASK << shift;
                misaligned = 1'b0;
            end
            mem_pkg::SIZE_HALF:
            begin
                mask       = mem_pkg::HALF_MASK << shift;
                misaligned = byte_offset[0];
            end
            mem_pkg::SIZE_WORD:
            begin
                mask       = mem_pkg::WORD_MASK;
                misaligned = |byte_offset;
            end
            default:
            begin
                // Reserved size code
                mask       = '0;
                misaligned = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/load_unit.sv ====
// ----------------------------------------------------------------------
// Load port with four-phase req/ack handshake
// Reads one RAM word through the arbiter and extracts the lanes
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      ld_req,
    input  wire mem_pkg::addr_t      ld_addr,
    input  wire mem_pkg::size_t      ld_size,
    output logic                     ld_ack,
    output mem_pkg::word_t           ld_data,
    output logic                     ld_misaligned,
    output logic                     mem_req,
    input  wire                      mem_gnt,
    output mem_pkg::word_addr_t      mem_addr,
    input  wire mem_pkg::word_t      mem_rdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_GRANT,
        S_READ,
        S_CAPTURE,
        S_ACK
    } state_t;

    state_t           state;
    mem_pkg::addr_t   addr_q;
    mem_pkg::size_t   size_q;
    mem_pkg::word_t   mask;
    mem_pkg::shift_t  shift;
    logic             misaligned;

    lane_align i_lane_align (
        .addr       (addr_q),
        .size       (size_q),
        .mask       (mask),
        .shift      (shift),
        .misaligned (misaligned)
    );

    // A refused access never asks for the RAM
    assign mem_req  = (state == S_WAIT_GRANT && !misaligned) || state == S_READ;
    assign mem_addr = addr_q[mem_pkg::ADDR_WIDTH-1:mem_pkg::OFFSET_BITS];

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state         <= S_IDLE;
            ld_ack        <= 1'b0;
            ld_misaligned <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (ld_req)
                        state <= S_WAIT_GRANT;
                S_WAIT_GRANT:
                    if (misaligned)
                    begin
                        ld_ack        <= 1'b1;
                        ld_misaligned <= 1'b1;
                        state         <= S_ACK;
                    end
                    else if (mem_gnt)
                        state <= S_READ;
                // Read issued here and data arrives in capture
                S_READ:
                    state <= S_CAPTURE;
                S_CAPTURE:
                begin
                    ld_ack <= 1'b1;
                    state  <= S_ACK;
                end
                S_ACK:
                    if (!ld_req)
                    begin
                        ld_ack        <= 1'b0;
                        ld_misaligned <= 1'b0;
                        state         <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && ld_req)
        begin
            addr_q <= ld_addr;
            size_q <= ld_size;
        end
        if (state == S_CAPTURE)
            ld_data <= (mem_rdata & mask) >> shift;
        else if (state == S_WAIT_GRANT && misaligned)
            ld_data <= '0;
    end

    // Ack is only raised on an edge that still saw req high
    ack_only_during_req: assert property (
        @(posedge clk) disable iff (!reset) $rose(ld_ack) |-> $past(ld_req));

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
// ----------------------------------------------------------------------
// Round-robin arbiter between the load and store units
// Owner keeps the RAM until it drops its request
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                      clk,
    input  wire                      reset,
    // Load client
    input  wire                      ld_mem_req,
    output logic                     ld_mem_gnt,
    input  wire mem_pkg::word_addr_t ld_mem_addr,
    output mem_pkg::word_t           ld_mem_rdata,
    // Store client
    input  wire                      st_mem_req,
    output logic                     st_mem_gnt,
    input  wire                      st_mem_we,
    input  wire mem_pkg::word_addr_t st_mem_addr,
    input  wire mem_pkg::word_t      st_mem_wdata,
    output mem_pkg::word_t           st_mem_rdata,
    // RAM side
    output logic                     ram_en,
    output logic                     ram_we,
    output mem_pkg::word_addr_t      ram_addr,
    output mem_pkg::word_t           ram_wdata,
    input  wire mem_pkg::word_t      ram_rdata
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_LD,
        OWN_ST
    } owner_t;

    owner_t owner;
    logic   last_st;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            owner   <= OWN_NONE;
            last_st <= 1'b1;
        end
        else
        begin
            case (owner)
                OWN_LD:
                    if (!ld_mem_req)
                        owner <= OWN_NONE;
                OWN_ST:
                    if (!st_mem_req)
                        owner <= OWN_NONE;
                default:
                    // On a tie the client not served last wins
                    if (ld_mem_req && (!st_mem_req || last_st))
                    begin
                        owner   <= OWN_LD;
                        last_st <= 1'b0;
                    end
                    else if (st_mem_req)
                    begin
                        owner   <= OWN_ST;
                        last_st <= 1'b1;
                    end
            endcase
        end
    end

    assign ld_mem_gnt = (owner == OWN_LD);
    assign st_mem_gnt = (owner == OWN_ST);

    // Only the owner reaches the RAM
    assign ram_en    = ld_mem_gnt || st_mem_gnt;
    assign ram_we    = st_mem_gnt && st_mem_we;
    assign ram_addr  = st_mem_gnt ? st_mem_addr : ld_mem_addr;
    assign ram_wdata = st_mem_gnt ? st_mem_wdata : '0;

    assign ld_mem_rdata = ram_rdata;
    assign st_mem_rdata = ram_rdata;

    one_grant_only: assert property (
        @(posedge clk) disable iff (!reset) !(ld_mem_gnt && st_mem_gnt));

endmodule

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
// ----------------------------------------------------------------------
// Shared widths, types and constants of the sub-word memory subsystem
// Word, byte address, RAM index, size code and lane shift types
// ----------------------------------------------------------------------
`default_nettype none

package mem_pkg;

    // Data path and address widths
    localparam int WORD_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 10;
    localparam int BYTES_PER_WORD  = 4;
    localparam int OFFSET_BITS     = $clog2(BYTES_PER_WORD);
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_BITS;
    localparam int SIZE_WIDTH      = 2;
    localparam int SHIFT_WIDTH     = $clog2(WORD_WIDTH);

    // RAM depth in words
    localparam int MEM_WORDS = 256;

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [SIZE_WIDTH-1:0]      size_t;
    typedef logic [SHIFT_WIDTH-1:0]     shift_t;

    // Access size codes, code 3 is never legal
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // Lane masks before shifting to the addressed byte
    localparam word_t BYTE_MASK = 32'h0000_00ff;
    localparam word_t HALF_MASK = 32'h0000_ffff;
    localparam word_t WORD_MASK = 32'hffff_ffff;

endpackage

`default_nettype wire

// ==== rtl/mem_subsystem.sv ====
// ----------------------------------------------------------------------
// Top of the memory access subsystem
// Load unit, store unit, arbiter and word RAM
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire                      clk,
    input  wire                      reset,
    // Load port
    input  wire                      ld_req,
    input  wire mem_pkg::addr_t      ld_addr,
    input  wire mem_pkg::size_t      ld_size,
    output logic                     ld_ack,
    output mem_pkg::word_t           ld_data,
    output logic                     ld_misaligned,
    // Store port
    input  wire                      st_req,
    input  wire mem_pkg::addr_t      st_addr,
    input  wire mem_pkg::size_t      st_size,
    input  wire mem_pkg::word_t      st_data,
    output logic                     st_ack,
    output logic                     st_misaligned
);

    logic                 ld_mem_req;
    logic                 ld_mem_gnt;
    mem_pkg::word_addr_t  ld_mem_addr;
    mem_pkg::word_t       ld_mem_rdata;

    logic                 st_mem_req;
    logic                 st_mem_gnt;
    logic                 st_mem_we;
    mem_pkg::word_addr_t  st_mem_addr;
    mem_pkg::word_t       st_mem_wdata;
    mem_pkg::word_t       st_mem_rdata;

    logic                 ram_en;
    logic                 ram_we;
    mem_pkg::word_addr_t  ram_addr;
    mem_pkg::word_t       ram_wdata;
    mem_pkg::word_t       ram_rdata;

    load_unit i_load_unit (
        .clk           (clk),
        .reset         (reset),
        .ld_req        (ld_req),
        .ld_addr       (ld_addr),
        .ld_size       (ld_size),
        .ld_ack        (ld_ack),
        .ld_data       (ld_data),
        .ld_misaligned (ld_misaligned),
        .mem_req       (ld_mem_req),
        .mem_gnt       (ld_mem_gnt),
        .mem_addr      (ld_mem_addr),
        .mem_rdata     (ld_mem_rdata)
    );

    store_unit i_store_unit (
        .clk           (clk),
        .reset         (reset),
        .st_req        (st_req),
        .st_addr       (st_addr),
        .st_size       (st_size),
        .st_data       (st_data),
        .st_ack        (st_ack),
        .st_misaligned (st_misaligned),
        .mem_req       (st_mem_req),
        .mem_gnt       (st_mem_gnt),
        .mem_we        (st_mem_we),
        .mem_addr      (st_mem_addr),
        .mem_wdata     (st_mem_wdata),
        .mem_rdata     (st_mem_rdata)
    );

    mem_arbiter i_mem_arbiter (
        .clk          (clk),
        .reset        (reset),
        .ld_mem_req   (ld_mem_req),
        .ld_mem_gnt   (ld_mem_gnt),
        .ld_mem_addr  (ld_mem_addr),
        .ld_mem_rdata (ld_mem_rdata),
        .st_mem_req   (st_mem_req),
        .st_mem_gnt   (st_mem_gnt),
        .st_mem_we    (st_mem_we),
        .st_mem_addr  (st_mem_addr),
        .st_mem_wdata (st_mem_wdata),
        .st_mem_rdata (st_mem_rdata),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata)
    );

    word_ram i_word_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/store_unit.sv ====
// ----------------------------------------------------------------------
// Store port with four-phase req/ack handshake
// Read-modify-write of the addressed lanes while holding the grant
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module store_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      st_req,
    input  wire mem_pkg::addr_t      st_addr,
    input  wire mem_pkg::size_t      st_size,
    input  wire mem_pkg::word_t      st_data,
    output logic                     st_ack,
    output logic                     st_misaligned,
    output logic                     mem_req,
    input  wire                      mem_gnt,
    output logic                     mem_we,
    output mem_pkg::word_addr_t      mem_addr,
    output mem_pkg::word_t           mem_wdata,
    input  wire mem_pkg::word_t      mem_rdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_GRANT,
        S_READ,
        S_MERGE,
        S_WRITE,
        S_ACK
    } state_t;

    state_t           state;
    mem_pkg::addr_t   addr_q;
    mem_pkg::size_t   size_q;
    mem_pkg::word_t   data_q;
    mem_pkg::word_t   merged_q;
    mem_pkg::word_t   mask;
    mem_pkg::shift_t  shift;
    logic             misaligned;

    lane_align i_lane_align (
        .addr       (addr_q),
        .size       (size_q),
        .mask       (mask),
        .shift      (shift),
        .misaligned (misaligned)
    );

    // Grant is kept from the read through the write back
    assign mem_req = (state == S_WAIT_GRANT && !misaligned)
                  || state == S_READ
                  || state == S_MERGE
                  || state == S_WRITE;

    assign mem_we    = (state == S_WRITE);
    assign mem_addr  = addr_q[mem_pkg::ADDR_WIDTH-1:mem_pkg::OFFSET_BITS];
    assign mem_wdata = merged_q;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state         <= S_IDLE;
            st_ack        <= 1'b0;
            st_misaligned <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (st_req)
                        state <= S_WAIT_GRANT;
                S_WAIT_GRANT:
                    if (misaligned)
                    begin
                        st_ack        <= 1'b1;
                        st_misaligned <= 1'b1;
                        state         <= S_ACK;
                    end
                    else if (mem_gnt)
                        state <= S_READ;
                S_READ:
                    state <= S_MERGE;
                S_MERGE:
                    state <= S_WRITE;
                S_WRITE:
                begin
                    st_ack <= 1'b1;
                    state  <= S_ACK;
                end
                S_ACK:
                    if (!st_req)
                    begin
                        st_ack        <= 1'b0;
                        st_misaligned <= 1'b0;
                        state         <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && st_req)
        begin
            addr_q <= st_addr;
            size_q <= st_size;
            data_q <= st_data;
        end
        // Old word is on mem_rdata during merge
        if (state == S_MERGE)
            merged_q <= (mem_rdata & ~mask) | ((data_q << shift) & mask);
    end

    // The write back must fall inside the grant held by the arbiter
    we_inside_grant: assert property (
        @(posedge clk) disable iff (!reset) mem_we |-> mem_gnt);

endmodule

`default_nettype wire

// ==== rtl/word_ram.sv ====
// ----------------------------------------------------------------------
// Single-port synchronous word RAM with one-cycle read latency
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module word_ram (
    input  wire                      clk,
    input  wire                      en,
    input  wire                      we,
    input  wire mem_pkg::word_addr_t addr,
    input  wire mem_pkg::word_t      wdata,
    output mem_pkg::word_t           rdata
);

    mem_pkg::word_t mem [mem_pkg::MEM_WORDS];

    // Read returns the old word on a write cycle
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/mem_pkg.sv
rtl/lane_align.sv
rtl/load_unit.sv
rtl/store_unit.sv
rtl/mem_arbiter.sv
rtl/word_ram.sv
rtl/mem_subsystem.sv
test/tb_mem_subsystem.sv

// ==== test/mem_trace.txt ====
# port addr size data misaligned pair (all numbers in hex)
# size 0 byte, 1 half, 2 word, 3 reserved; data is store data or expected load data
# pair 1 runs the line together with the next line on the other port
S 000 2 deadbeef 0 0
L 000 2 deadbeef 0 0
S 004 2 11223344 0 0
S 005 0 000000aa 0 0
L 004 2 1122aa44 0 0
S 006 1 0000beef 0 0
L 004 2 beefaa44 0 0
L 005 0 000000aa 0 0
L 006 1 0000beef 0 0
L 007 0 000000be 0 0
L 003 0 000000de 0 0
L 000 1 0000beef 0 0
L 002 1 0000dead 0 0
S 008 2 00000000 0 0
S 00a 0 ffffff5a 0 0
L 008 2 005a0000 0 0
S 005 1 ffffffff 1 0
S 006 2 ffffffff 1 0
S 004 3 ffffffff 1 0
L 001 2 00000000 1 0
L 003 1 00000000 1 0
L 000 3 00000000 1 0
L 004 2 beefaa44 0 0
L 000 2 deadbeef 0 1
S 00c 2 cafef00d 0 0
S 010 2 01234567 0 1
L 004 2 beefaa44 0 0
L 00c 2 cafef00d 0 0
L 010 2 01234567 0 0
S 012 1 00009abc 0 1
L 00d 0 000000f0 0 0
L 010 2 9abc4567 0 0

// ==== test/tb_mem_subsystem.sv ====
// ----------------------------------------------------------------------
// Trace-driven testbench for the memory access subsystem
// Load and store drivers, compare tasks, protocol monitor and watchdog
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int CLK_PERIOD    = 8;
    localparam int CYCLES_PER_OP = 40;
    localparam int MAX_OPS       = 64;
    localparam logic [31:0] SEED = 32'h1becc30d;

    logic                clk = 1'b0;
    logic                reset;
    logic                ld_req;
    mem_pkg::addr_t      ld_addr;
    mem_pkg::size_t      ld_size;
    logic                ld_ack;
    mem_pkg::word_t      ld_data;
    logic                ld_misaligned;
    logic                st_req;
    mem_pkg::addr_t      st_addr;
    mem_pkg::size_t      st_size;
    mem_pkg::word_t      st_data;
    logic                st_ack;
    logic                st_misaligned;

    // Operations read from the trace
    logic [7:0]          op_port [MAX_OPS];
    mem_pkg::addr_t      op_addr [MAX_OPS];
    mem_pkg::size_t      op_size [MAX_OPS];
    mem_pkg::word_t      op_data [MAX_OPS];
    logic                op_mis  [MAX_OPS];
    logic                op_pair [MAX_OPS];
    int                  n_ops = 0;
    logic                trace_ready = 1'b0;
    logic [31:0]         rng_state;

    logic ld_req_q = 1'b0;
    logic ld_ack_q = 1'b0;
    logic st_req_q = 1'b0;
    logic st_ack_q = 1'b0;

    mem_subsystem i_mem_subsystem (
        .clk           (clk),
        .reset         (reset),
        .ld_req        (ld_req),
        .ld_addr       (ld_addr),
        .ld_size       (ld_size),
        .ld_ack        (ld_ack),
        .ld_data       (ld_data),
        .ld_misaligned (ld_misaligned),
        .st_req        (st_req),
        .st_addr       (st_addr),
        .st_size       (st_size),
        .st_data       (st_data),
        .st_ack        (st_ack),
        .st_misaligned (st_misaligned)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Idle gap or back-pressure length of 0 to 3 cycles
    task automatic draw_cycles(output int cycles);
        rng_state = xorshift32(rng_state);
        cycles = int'(rng_state[1:0]);
    endtask

    task automatic read_trace();
        int fd;
        int r;
        int c;
        logic [7:0]  port;
        logic [31:0] a;
        logic [31:0] s;
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] p;
        logic        done;
        fd = $fopen("test/mem_trace.txt", "r");
        if (fd == 0)
            fail_run("Could not open the trace file test/mem_trace.txt");
        else
        begin
            done = 1'b0;
            while (!done)
            begin
                r = $fscanf(fd, " %c", port);
                if (r != 1)
                    done = 1'b1;
                else if (port == "#")
                begin
                    // Skip the rest of a comment line
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1)
                        c = $fgetc(fd);
                end
                else if ((port != "L" && port != "S") || n_ops == MAX_OPS)
                    fail_run("Trace line has an unknown port or the trace is too long");
                else
                begin
                    r = $fscanf(fd, " %h %h %h %h %h", a, s, d, m, p);
                    if (r != 5)
                        fail_run("Trace line does not have all six columns");
                    else
                    begin
                        op_port[n_ops] = port;
                        op_addr[n_ops] = mem_pkg::addr_t'(a);
                        op_size[n_ops] = mem_pkg::size_t'(s);
                        op_data[n_ops] = d;
                        op_mis[n_ops]  = m[0];
                        op_pair[n_ops] = p[0];
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_load(input int idx, input int gap, input int hold);
        repeat (gap) @(negedge clk);
        @(negedge clk);
        check_flag("ld_ack", ld_ack, 1'b0);
        ld_req  = 1'b1;
        ld_addr = op_addr[idx];
        ld_size = op_size[idx];
        do @(negedge clk); while (ld_ack !== 1'b1);
        check_flag("ld_misaligned", ld_misaligned, op_mis[idx]);
        if (!op_mis[idx])
            check_word("ld_data", ld_data, op_data[idx]);
        // Requester holds req and ack must stay up
        repeat (hold) @(negedge clk);
        check_flag("ld_ack", ld_ack, 1'b1);
        ld_req = 1'b0;
        do @(negedge clk); while (ld_ack !== 1'b0);
    endtask

    task automatic run_store(input int idx, input int gap, input int hold);
        repeat (gap) @(negedge clk);
        @(negedge clk);
        check_flag("st_ack", st_ack, 1'b0);
        st_req  = 1'b1;
        st_addr = op_addr[idx];
        st_size = op_size[idx];
        st_data = op_data[idx];
        do @(negedge clk); while (st_ack !== 1'b1);
        check_flag("st_misaligned", st_misaligned, op_mis[idx]);
        repeat (hold) @(negedge clk);
        check_flag("st_ack", st_ack, 1'b1);
        st_req = 1'b0;
        do @(negedge clk); while (st_ack !== 1'b0);
    endtask

    task automatic run_op(input int idx, input int gap, input int hold);
        if (op_port[idx] == "L")
            run_load(idx, gap, hold);
        else
            run_store(idx, gap, hold);
    endtask

    // Four-phase order on both ports against req at the edge that moved ack
    always @(posedge clk)
    begin
        if (reset === 1'b1)
        begin
            if (ld_ack && !ld_ack_q && !ld_req_q)
                fail_run("ld_ack rose while ld_req was low");
            if (!ld_ack && ld_ack_q && ld_req_q)
                fail_run("ld_ack fell while ld_req was still high");
            if (st_ack && !st_ack_q && !st_req_q)
                fail_run("st_ack rose while st_req was low");
            if (!st_ack && st_ack_q && st_req_q)
                fail_run("st_ack fell while st_req was still high");
        end
        ld_req_q <= ld_req;
        ld_ack_q <= ld_ack;
        st_req_q <= st_req;
        st_ack_q <= st_ack;
    end

    // Watchdog scaled to the trace length
    initial
    begin
        wait (trace_ready);
        #(n_ops * CYCLES_PER_OP * CLK_PERIOD);
        fail_run($sformatf("Run timed out after %0d cycles", n_ops * CYCLES_PER_OP));
    end

    initial
    begin
        int idx;
        int gap_a;
        int hold_a;
        int gap_b;
        int hold_b;
        reset     = 1'b0;
        ld_req    = 1'b0;
        ld_addr   = '0;
        ld_size   = '0;
        st_req    = 1'b0;
        st_addr   = '0;
        st_size   = '0;
        st_data   = '0;
        rng_state = SEED;
        read_trace();
        trace_ready = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        check_flag("ld_ack", ld_ack, 1'b0);
        check_flag("st_ack", st_ack, 1'b0);

        idx = 0;
        while (idx < n_ops)
        begin
            draw_cycles(gap_a);
            draw_cycles(hold_a);
            if (op_pair[idx])
            begin
                if (idx + 1 >= n_ops || op_port[idx] == op_port[idx + 1])
                    fail_run("Trace pair needs a following line on the other port");
                draw_cycles(gap_b);
                draw_cycles(hold_b);
                fork
                    run_op(idx, gap_a, hold_a);
                    run_op(idx + 1, gap_b, hold_b);
                join
                idx = idx + 2;
            end
            else
            begin
                run_op(idx, gap_a, hold_a);
                idx = idx + 1;
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
